// File: hdl/cpuPkg.sv
package cpuPkg;

	localparam int WordWidth   = 32;
	localparam int NumRegs     = 32;
	localparam int OffsetWidth = 16;

	// Instruction field positions
	localparam int OpcodeLsb = 26;
	localparam int RsLsb     = 21;
	localparam int RtLsb     = 16;
	localparam int ShamtLsb  = 6;
	localparam int FuncLsb   = 0;
	localparam int JumpLsb   = 0;

	typedef logic [WordWidth-1:0] word_t;
	typedef logic [31:0]          instr_t;
	typedef logic [4:0]           regIdx_t;
	typedef logic [5:0]           opcode_t;
	typedef logic [5:0]           funcCode_t;

	localparam regIdx_t LinkReg = 5'd31;

	typedef enum opcode_t {
		ALU_R  = 6'd0,
		ALU_I  = 6'd1,
		SHIFT  = 6'd2,
		LOAD   = 6'd3,
		STORE  = 6'd4,
		BRANCH = 6'd5,
		JUMP   = 6'd6,
		JAL    = 6'd7,
		JR     = 6'd8,
		HALT   = 6'h3f
	} opcodeVal_e;

	typedef enum logic [2:0] {
		ALU_ADD, ALU_SUB, ALU_AND, ALU_XOR, ALU_SLL, ALU_SRL, ALU_SRA
	} aluOp_e;

	typedef enum logic [1:0] {SRC_RT, SRC_OFFSET, SRC_SHAMT} aluSrc_e;
	typedef enum logic [1:0] {DEST_RS, DEST_RT, DEST_LINK} regDest_e;
	typedef enum logic [1:0] {WB_ALU, WB_MEM, WB_PC1} wbSel_e;

	// Branch kinds, low 3 bits of funcCode pick one for BRANCH
	typedef enum logic [2:0] {
		BR_NONE, BR_JUMP, BR_BLTZ, BR_BZ, BR_BNZ, BR_BCY, BR_BNCY, BR_JR
	} branch_e;

	typedef enum logic {RUN, HALTED} ctrlState_e;

	typedef struct packed {
		aluOp_e   aluOp;
		aluSrc_e  aluSrc;
		regDest_e regDest;
		logic     regWrite;
		logic     memWrite;
		wbSel_e   wbSel;
		branch_e  branch;
		logic     carryWrite;
	} ctrl_t;

endpackage

// File: hdl/controlUnit.sv
`timescale 1ns/1ps

module controlUnit (
	input  logic              clk,
	input  logic              rst,
	input  cpuPkg::opcode_t   opcode,
	input  cpuPkg::funcCode_t funcCode,
	output cpuPkg::ctrl_t     ctrl,
	output logic              halted
);
	import cpuPkg::*;

	ctrlState_e state;
	ctrl_t      dec;    // Raw decode before gating

	always_ff @(posedge clk) begin
		if (rst)
			state <= RUN;
		else if (state == RUN && opcode == HALT)
			state <= HALTED;
	end

	assign halted = (state == HALTED);

	////////////////////////////////////////////////////////////
	// Opcode decode
	////////////////////////////////////////////////////////////
	always_comb begin
		dec = '0;
		case (opcode)
			ALU_R, SHIFT: begin
				dec.aluOp    = aluOp_e'(funcCode[2:0]);
				dec.aluSrc   = (opcode == SHIFT) ? SRC_SHAMT : SRC_RT;
				dec.regDest  = DEST_RS;
				dec.regWrite = 1'b1;
				dec.carryWrite = (dec.aluOp inside {ALU_ADD, ALU_SUB});
			end
			ALU_I: begin
				dec.aluOp    = aluOp_e'(funcCode[2:0]);   // Shares bits with the offset
				dec.aluSrc   = SRC_OFFSET;
				dec.regDest  = DEST_RS;
				dec.regWrite = 1'b1;
				dec.carryWrite = (dec.aluOp inside {ALU_ADD, ALU_SUB});
			end
			LOAD: begin
				dec.aluSrc   = SRC_OFFSET;
				dec.regDest  = DEST_RT;
				dec.regWrite = 1'b1;
				dec.wbSel    = WB_MEM;
			end
			STORE: begin
				dec.aluSrc   = SRC_OFFSET;
				dec.memWrite = 1'b1;
			end
			BRANCH: begin
				case (branch_e'(funcCode[2:0]))
					BR_BLTZ, BR_BZ, BR_BNZ, BR_BCY, BR_BNCY: dec.branch = branch_e'(funcCode[2:0]);
					default: dec.branch = BR_NONE;
				endcase
			end
			JUMP: dec.branch = BR_JUMP;
			JAL: begin
				dec.branch   = BR_JUMP;
				dec.regDest  = DEST_LINK;
				dec.wbSel    = WB_PC1;
				dec.regWrite = 1'b1;
			end
			JR: dec.branch = BR_JR;
			default: dec = '0;   // HALT and unknown opcodes do nothing here
		endcase
	end

	always_comb begin
		ctrl = dec;
		if (rst || halted) begin
			ctrl.regWrite   = 1'b0;
			ctrl.memWrite   = 1'b0;
			ctrl.carryWrite = 1'b0;
			ctrl.branch     = BR_NONE;
		end
	end

	noWriteClash: assert property (@(posedge clk) !(ctrl.memWrite && ctrl.regWrite));

endmodule

// File: hdl/instrDecoder.sv
`timescale 1ns/1ps

module instrDecoder #(
	parameter int ImemAddrWidth = 8
) (
	input  cpuPkg::instr_t          instr,
	output cpuPkg::opcode_t         opcode,
	output cpuPkg::funcCode_t       funcCode,
	output cpuPkg::regIdx_t         rs,
	output cpuPkg::regIdx_t         rt,
	output cpuPkg::word_t           shamt,
	output cpuPkg::word_t           offset,
	output logic [ImemAddrWidth-1:0] jumpAddr
);
	import cpuPkg::*;

	assign opcode   = instr[OpcodeLsb +: 6];
	assign funcCode = instr[FuncLsb +: 6];
	assign rs       = instr[RsLsb +: 5];
	assign rt       = instr[RtLsb +: 5];

	// Extension of the short fields
	assign shamt  = {{(WordWidth-5){1'b0}}, instr[ShamtLsb +: 5]};
	assign offset = {{(WordWidth-OffsetWidth){instr[OffsetWidth-1]}}, instr[OffsetWidth-1:0]};

	assign jumpAddr = instr[JumpLsb +: ImemAddrWidth];   // Upper bits of the 26-bit field dropped

endmodule

// File: hdl/regFile.sv
`timescale 1ns/1ps

module regFile (
	input  logic            clk,
	input  logic            rst,
	input  cpuPkg::regIdx_t rsIdx,
	input  cpuPkg::regIdx_t rtIdx,
	input  cpuPkg::regIdx_t wrIdx,
	input  cpuPkg::word_t   wrData,
	input  logic            wrEn,
	output cpuPkg::word_t   rsData,
	output cpuPkg::word_t   rtData
);
	import cpuPkg::*;

	word_t regs [NumRegs];

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < NumRegs; i++)
				regs[i] <= '0;
		end else if (wrEn) begin
			regs[wrIdx] <= wrData;   // r0 may be written but is never read back
		end
	end

	// Asynchronous reads
	assign rsData = (rsIdx == '0) ? '0 : regs[rsIdx];
	assign rtData = (rtIdx == '0) ? '0 : regs[rtIdx];

endmodule

// File: hdl/alu.sv
`timescale 1ns/1ps

module alu (
	input  logic            clk,
	input  logic            rst,
	input  cpuPkg::word_t   a,
	input  cpuPkg::word_t   rt,
	input  cpuPkg::word_t   shamt,
	input  cpuPkg::word_t   offset,
	input  cpuPkg::aluSrc_e aluSrc,
	input  cpuPkg::aluOp_e  aluOp,
	input  logic            carryWrite,
	output cpuPkg::word_t   result,
	output logic            zero,
	output logic            sign,
	output logic            carryFlag
);
	import cpuPkg::*;

	word_t            b;
	logic [WordWidth:0] sum;    // Extra bit holds carry-out
	logic [4:0]       shAmt;

	always_comb begin
		case (aluSrc)
			SRC_OFFSET: b = offset;
			SRC_SHAMT:  b = shamt;
			default:    b = rt;
		endcase
	end

	assign shAmt = b[4:0];

	// Sub as a + ~b + 1 so the carry comes out the same way
	assign sum = (aluOp == ALU_SUB) ? ({1'b0, a} + {1'b0, ~b} + 1'b1)
	                                : ({1'b0, a} + {1'b0, b});

	always_comb begin
		case (aluOp)
			ALU_AND: result = a & b;
			ALU_XOR: result = a ^ b;
			ALU_SLL: result = a << shAmt;
			ALU_SRL: result = a >> shAmt;
			ALU_SRA: result = word_t'($signed(a) >>> shAmt);
			default: result = sum[WordWidth-1:0];   // Add, sub and the unused code
		endcase
	end

	assign zero = (result == '0);
	assign sign = result[WordWidth-1];

	////////////////////////////////////////////////////////////
	// Carry flag
	////////////////////////////////////////////////////////////
	always_ff @(posedge clk) begin
		if (rst)
			carryFlag <= 1'b0;
		else if (carryWrite)
			carryFlag <= sum[WordWidth];
	end

	// Only add and sub may update the carry
	carryOnlyArith: assert property (@(posedge clk) disable iff (rst)
		carryWrite |-> (aluOp inside {ALU_ADD, ALU_SUB}));

endmodule

// File: hdl/branchUnit.sv
`timescale 1ns/1ps

module branchUnit #(
	parameter int ImemAddrWidth = 8
) (
	input  logic                     clk,
	input  logic                     rst,
	input  logic                     halted,
	input  cpuPkg::branch_e          branch,
	input  cpuPkg::word_t            rsData,
	input  cpuPkg::word_t            offset,
	input  logic [ImemAddrWidth-1:0] jumpAddr,
	input  logic                     carryFlag,
	output logic [ImemAddrWidth-1:0] pc,
	output logic [ImemAddrWidth-1:0] pcPlusOne
);
	import cpuPkg::*;

	logic                     taken;
	logic [ImemAddrWidth-1:0] nextPc;

	assign pcPlusOne = pc + 1'b1;

	always_comb begin
		case (branch)
			BR_BLTZ: taken = rsData[WordWidth-1];
			BR_BZ:   taken = (rsData == '0);
			BR_BNZ:  taken = (rsData != '0);
			BR_BCY:  taken = carryFlag;
			BR_BNCY: taken = !carryFlag;
			default: taken = 1'b0;
		endcase
	end

	always_comb begin
		case (branch)
			BR_JUMP: nextPc = jumpAddr;
			BR_JR:   nextPc = rsData[ImemAddrWidth-1:0];
			default: nextPc = taken ? pcPlusOne + offset[ImemAddrWidth-1:0] : pcPlusOne;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst)
			pc <= '0;
		else if (!halted)
			pc <= nextPc;
	end

	// A halted core issues no branch
	haltNoBranch: assert property (@(posedge clk) disable iff (rst)
		halted |-> (branch == BR_NONE));

endmodule

// File: hdl/instrMemory.sv
`timescale 1ns/1ps

module instrMemory #(
	parameter int ImemAddrWidth = 8
) (
	input  logic                     clk,
	input  logic [ImemAddrWidth-1:0] addr,
	output cpuPkg::instr_t           instr,
	input  logic                     progWe,
	input  logic [ImemAddrWidth-1:0] progAddr,
	input  cpuPkg::instr_t           progData
);
	import cpuPkg::*;

	instr_t mem [2**ImemAddrWidth];

	always_ff @(posedge clk) begin
		if (progWe)
			mem[progAddr] <= progData;   // Program load
	end

	assign instr = mem[addr];

endmodule

// File: hdl/dataMemory.sv
`timescale 1ns/1ps

module dataMemory #(
	parameter int DmemAddrWidth = 8
) (
	input  logic          clk,
	input  cpuPkg::word_t addr,
	input  cpuPkg::word_t wrData,
	input  logic          we,
	output cpuPkg::word_t rdData
);
	import cpuPkg::*;

	word_t mem [2**DmemAddrWidth];

	// Word address wraps at the array size
	always_ff @(posedge clk) begin
		if (we)
			mem[addr[DmemAddrWidth-1:0]] <= wrData;
	end

	assign rdData = mem[addr[DmemAddrWidth-1:0]];

endmodule

// File: hdl/dataPath.sv
`timescale 1ns/1ps

module dataPath #(
	parameter int ImemAddrWidth = 8,
	parameter int DmemAddrWidth = 8
) (
	input  logic                     clk,
	input  logic                     rst,
	input  cpuPkg::ctrl_t            ctrl,
	input  logic                     halted,
	output cpuPkg::opcode_t          opcode,
	output cpuPkg::funcCode_t        funcCode,
	input  logic                     progWe,
	input  logic [ImemAddrWidth-1:0] progAddr,
	input  cpuPkg::instr_t           progData,
	output logic [ImemAddrWidth-1:0] pc,
	output logic                     wbEn,
	output cpuPkg::regIdx_t          wbReg,
	output cpuPkg::word_t            wbData,
	output logic                     memWe,
	output cpuPkg::word_t            memAddr,
	output cpuPkg::word_t            memWData
);
	import cpuPkg::*;

	instr_t                   instr;
	regIdx_t                  rs, rt, wrIdx;
	word_t                    shamt, offset, rsData, rtData, aluResult, memRdData;
	logic [ImemAddrWidth-1:0] jumpAddr, pcPlusOne;
	logic                     carryFlag;

	instrMemory #(.ImemAddrWidth(ImemAddrWidth)) i_instrMemory (
		.clk(clk), .addr(pc), .instr(instr),
		.progWe(progWe), .progAddr(progAddr), .progData(progData)
	);

	instrDecoder #(.ImemAddrWidth(ImemAddrWidth)) i_instrDecoder (
		.instr(instr), .opcode(opcode), .funcCode(funcCode), .rs(rs), .rt(rt),
		.shamt(shamt), .offset(offset), .jumpAddr(jumpAddr)
	);

	////////////////////////////////////////////////////////////
	// Destination and writeback muxes
	////////////////////////////////////////////////////////////
	always_comb begin
		case (ctrl.regDest)
			DEST_RT:   wrIdx = rt;
			DEST_LINK: wrIdx = LinkReg;
			default:   wrIdx = rs;
		endcase
		case (ctrl.wbSel)
			WB_MEM:  wbData = memRdData;
			WB_PC1:  wbData = word_t'(pcPlusOne);   // Return address for jal
			default: wbData = aluResult;
		endcase
	end

	regFile i_regFile (
		.clk(clk), .rst(rst), .rsIdx(rs), .rtIdx(rt), .wrIdx(wrIdx),
		.wrData(wbData), .wrEn(ctrl.regWrite), .rsData(rsData), .rtData(rtData)
	);

	alu i_alu (
		.clk(clk), .rst(rst), .a(rsData), .rt(rtData), .shamt(shamt), .offset(offset),
		.aluSrc(ctrl.aluSrc), .aluOp(ctrl.aluOp), .carryWrite(ctrl.carryWrite),
		.result(aluResult), .zero(), .sign(), .carryFlag(carryFlag)
	);

	branchUnit #(.ImemAddrWidth(ImemAddrWidth)) i_branchUnit (
		.clk(clk), .rst(rst), .halted(halted), .branch(ctrl.branch), .rsData(rsData),
		.offset(offset), .jumpAddr(jumpAddr), .carryFlag(carryFlag),
		.pc(pc), .pcPlusOne(pcPlusOne)
	);

	dataMemory #(.DmemAddrWidth(DmemAddrWidth)) i_dataMemory (
		.clk(clk), .addr(aluResult), .wrData(rtData), .we(ctrl.memWrite), .rdData(memRdData)
	);

	assign wbEn     = ctrl.regWrite;
	assign wbReg    = wrIdx;
	assign memWe    = ctrl.memWrite;
	assign memAddr  = aluResult;   // rs + offset for load and store
	assign memWData = rtData;

endmodule

// File: hdl/cpuTop.sv
`timescale 1ns/1ps

module cpuTop #(
	parameter int ImemAddrWidth = 8,
	parameter int DmemAddrWidth = 8
) (
	input  logic                     clk,
	input  logic                     rst,
	input  logic                     progWe,
	input  logic [ImemAddrWidth-1:0] progAddr,
	input  cpuPkg::instr_t           progData,
	output logic [ImemAddrWidth-1:0] pc,
	output logic                     wbEn,
	output cpuPkg::regIdx_t          wbReg,
	output cpuPkg::word_t            wbData,
	output logic                     memWe,
	output cpuPkg::word_t            memAddr,
	output cpuPkg::word_t            memWData,
	output logic                     halted
);
	import cpuPkg::*;

	opcode_t   opcode;
	funcCode_t funcCode;
	ctrl_t     ctrl;

	controlUnit i_controlUnit (
		.clk(clk), .rst(rst), .opcode(opcode), .funcCode(funcCode),
		.ctrl(ctrl), .halted(halted)
	);

	dataPath #(
		.ImemAddrWidth(ImemAddrWidth),
		.DmemAddrWidth(DmemAddrWidth)
	) i_dataPath (
		.clk(clk), .rst(rst), .ctrl(ctrl), .halted(halted),
		.opcode(opcode), .funcCode(funcCode),
		.progWe(progWe), .progAddr(progAddr), .progData(progData),
		.pc(pc), .wbEn(wbEn), .wbReg(wbReg), .wbData(wbData),
		.memWe(memWe), .memAddr(memAddr), .memWData(memWData)
	);

endmodule

// File: dv/cpuTb.sv
`timescale 1ns/1ps

module cpuTb;
	import cpuPkg::*;

	localparam int ImemAddrWidth = 8;
	localparam int DmemAddrWidth = 8;
	localparam int ClkPeriod     = 10;
	localparam int ResetCycles   = 10;
	localparam int HaltCycles    = 5;
	localparam int NumRandom     = 10;
	localparam int RandLen       = 40;
	localparam int TotalWords    = 4 * 48 + NumRandom * RandLen;   // Directed programs stay under 48
	localparam instr_t HaltWord  = {HALT, 26'd0};

	// Expected port values for one cycle
	typedef struct packed {
		logic [ImemAddrWidth-1:0] pc;
		logic                     wbEn;
		regIdx_t                  wbReg;
		word_t                    wbData;
		logic                     memWe;
		word_t                    memAddr;
		word_t                    memWData;
		logic                     halted;
	} obs_t;

	logic                     clk = 1'b0;
	logic                     rst;
	logic                     progWe;
	logic [ImemAddrWidth-1:0] progAddr;
	instr_t                   progData;
	logic [ImemAddrWidth-1:0] pc;
	logic                     wbEn;
	regIdx_t                  wbReg;
	word_t                    wbData;
	logic                     memWe;
	word_t                    memAddr;
	word_t                    memWData;
	logic                     halted;

	// Model state
	word_t                    mRegs [32];
	word_t                    mMem [2**DmemAddrWidth];   // Not reset, like the DUT memory
	instr_t                   progMem [2**ImemAddrWidth];
	logic [ImemAddrWidth-1:0] mPc;
	logic                     mCarry;
	logic                     mHalted;

	instr_t      prog [$];
	obs_t        expObs;
	logic        active = 1'b0;
	logic [31:0] rngState = 32'd36;
	int          errCount = 0;
	int          checkCount = 0;
	int          testCount = 0;

	cpuTop #(
		.ImemAddrWidth(ImemAddrWidth),
		.DmemAddrWidth(DmemAddrWidth)
	) i_cpuTop (
		.clk(clk), .rst(rst), .progWe(progWe), .progAddr(progAddr), .progData(progData),
		.pc(pc), .wbEn(wbEn), .wbReg(wbReg), .wbData(wbData),
		.memWe(memWe), .memAddr(memAddr), .memWData(memWData), .halted(halted)
	);

	always #(ClkPeriod / 2) clk = ~clk;

	function automatic logic [31:0] nextRandom();
		rngState ^= rngState << 13;
		rngState ^= rngState >> 17;
		rngState ^= rngState << 5;
		return rngState;
	endfunction

	////////////////////////////////////////////////////////////
	// Instruction encoders
	////////////////////////////////////////////////////////////
	function automatic instr_t makeReg(opcode_t op, regIdx_t rs, regIdx_t rt,
	                                   logic [4:0] shamt, funcCode_t fn);
		return {op, rs, rt, 5'd0, shamt, fn};
	endfunction

	function automatic instr_t makeImm(opcode_t op, regIdx_t rs, regIdx_t rt, logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	function automatic instr_t makeJump(opcode_t op, logic [25:0] addr);
		return {op, addr};
	endfunction

	// Low three offset bits double as the branch kind
	function automatic instr_t makeBranch(regIdx_t rs, branch_e kind, int steps);
		return makeImm(BRANCH, rs, 5'd0, 16'(kind) + 16'(8 * steps));
	endfunction

	task automatic addFiller(input int n);
		repeat (n) prog.push_back(makeImm(ALU_I, 5'd9, 5'd0, 16'h0008));   // Visible if not skipped
	endtask

	function automatic void modelReset();
		foreach (mRegs[i])
			mRegs[i] = '0;
		mPc = '0;
		mCarry = 1'b0;
		mHalted = 1'b0;
	endfunction

	////////////////////////////////////////////////////////////
	// Instruction-set reference, one instruction per call
	////////////////////////////////////////////////////////////
	function automatic obs_t refStep();
		instr_t                   ins;
		opcode_t                  op;
		regIdx_t                  rs;
		regIdx_t                  rt;
		logic [2:0]               fn;
		word_t                    a;
		word_t                    b;
		word_t                    imm;
		word_t                    res;
		logic [32:0]              sum;
		logic                     taken;
		logic [ImemAddrWidth-1:0] nextPc;
		obs_t                     o;
		ins = progMem[mPc];
		op  = ins[31:26];
		rs  = ins[25:21];
		rt  = ins[20:16];
		fn  = ins[2:0];
		imm = {{16{ins[15]}}, ins[15:0]};
		a   = mRegs[rs];
		b   = mRegs[rt];
		o   = '0;
		o.pc = mPc;
		o.halted = mHalted;
		if (mHalted)
			return o;   // PC frozen, strobes idle
		nextPc = mPc + 1'b1;
		case (op)
			ALU_R, ALU_I, SHIFT: begin
				if (op == ALU_I)
					b = imm;
				else if (op == SHIFT)
					b = word_t'(ins[10:6]);
				sum = {1'b0, a} + {1'b0, b};
				case (fn)
					ALU_SUB: res = a - b;
					ALU_AND: res = a & b;
					ALU_XOR: res = a ^ b;
					ALU_SLL: res = a << b[4:0];
					ALU_SRL: res = a >> b[4:0];
					ALU_SRA: res = $signed(a) >>> b[4:0];
					default: res = sum[31:0];
				endcase
				if (fn == ALU_ADD)
					mCarry = sum[32];
				else if (fn == ALU_SUB)
					mCarry = (a >= b);   // No borrow means carry out
				o.wbEn = 1'b1;
				o.wbReg = rs;
				o.wbData = res;
			end
			LOAD: begin
				o.wbEn = 1'b1;
				o.wbReg = rt;
				o.wbData = mMem[(a + imm) % (2**DmemAddrWidth)];
			end
			STORE: begin
				o.memWe = 1'b1;
				o.memAddr = a + imm;
				o.memWData = b;
				mMem[o.memAddr % (2**DmemAddrWidth)] = b;
			end
			BRANCH: begin
				case (fn)
					BR_BLTZ: taken = a[31];
					BR_BZ:   taken = (a == 0);
					BR_BNZ:  taken = (a != 0);
					BR_BCY:  taken = mCarry;
					BR_BNCY: taken = !mCarry;
					default: taken = 1'b0;
				endcase
				if (taken)
					nextPc = mPc + 1'b1 + imm[ImemAddrWidth-1:0];
			end
			JUMP: nextPc = ins[ImemAddrWidth-1:0];
			JAL: begin
				o.wbEn = 1'b1;
				o.wbReg = LinkReg;
				o.wbData = word_t'(nextPc);
				nextPc = ins[ImemAddrWidth-1:0];
			end
			JR:   nextPc = a[ImemAddrWidth-1:0];
			HALT: mHalted = 1'b1;
			default: ;
		endcase
		if (o.wbEn && o.wbReg != 0)
			mRegs[o.wbReg] = o.wbData;
		mPc = nextPc;
		return o;
	endfunction

	task automatic compareValue(input string sig, input word_t expVal, input word_t actVal);
		checkCount++;
		assert (actVal === expVal) else begin
			$display("Fail %s: expected %h, actual %h at %0t", sig, expVal, actVal, $time);
			errCount++;
		end
	endtask

	// Sample just before each rising edge
	always @(posedge clk) begin
		#(ClkPeriod - 1);
		if (rst) begin
			compareValue("wbEn", 0, wbEn);
			compareValue("memWe", 0, memWe);
		end else if (active) begin
			expObs = refStep();
			compareValue("pc", word_t'(expObs.pc), word_t'(pc));
			compareValue("wbEn", expObs.wbEn, wbEn);
			if (expObs.wbEn) begin
				compareValue("wbReg", expObs.wbReg, wbReg);
				compareValue("wbData", expObs.wbData, wbData);
			end
			compareValue("memWe", expObs.memWe, memWe);
			if (expObs.memWe) begin
				compareValue("memAddr", expObs.memAddr, memAddr);
				compareValue("memWData", expObs.memWData, memWData);
			end
			compareValue("halted", expObs.halted, halted);
		end
	end

	initial begin
		#(TotalWords * 20 * ClkPeriod);
		$display("Watchdog expired, a program did not reach HALT");
		$display("TEST FAILED");
		$finish;
	end

	// Load under reset, run to HALT, then watch the halted state
	task automatic runTest(input string name);
		int errStart;
		int cycles;
		int nWords;
		errStart = errCount;
		nWords = prog.size() + 1;   // Padding HALT after the program
		active = 1'b0;
		rst = 1'b1;
		for (int i = 0; i < nWords || i < ResetCycles; i++) begin
			@(posedge clk);
			#1;
			progWe = (i < nWords);
			progAddr = ImemAddrWidth'(i);
			progData = (i < prog.size()) ? prog[i] : HaltWord;
			if (i < nWords)
				progMem[i] = progData;
		end
		modelReset();
		@(posedge clk);
		#1;
		progWe = 1'b0;
		rst = 1'b0;
		active = 1'b1;
		cycles = 0;
		while (halted !== 1'b1) begin
			@(posedge clk);
			#1;
			cycles++;
		end
		repeat (HaltCycles) @(posedge clk);
		#1;
		active = 1'b0;
		rst = 1'b1;
		testCount++;
		$display("%-10s %4d cycles, %0d errors", name, cycles, errCount - errStart);
	endtask

	task automatic buildRandom(input int len);
		logic [31:0] r;
		int          maxD;
		int          kind;
		prog.delete();
		for (int i = 0; i < 8; i++)
			prog.push_back(makeImm(STORE, 5'd0, 5'(i), 16'(i)));   // Defines load window 0..7
		while (prog.size() < len - 1) begin
			r = nextRandom();
			maxD = len - 2 - prog.size();   // Farthest forward step that still lands in range
			case (r[2:0])
				0, 1: prog.push_back(makeReg(ALU_R, r[7:3], r[12:8], r[17:13], 6'(r[20:18] % 7)));
				2: prog.push_back(makeImm(ALU_I, r[7:3], r[12:8], {r[25:13], 3'(r[28:26] % 7)}));
				3: prog.push_back(makeReg(SHIFT, r[7:3], 5'd0, r[12:8], 6'(4 + r[14:13] % 3)));
				4: prog.push_back(makeImm(LOAD, 5'd0, r[7:3], 16'(r[10:8])));
				5: prog.push_back(makeImm(STORE, r[7:3], r[12:8], r[28:13]));
				6: begin
					kind = 2 + r[5:3] % 5;
					if (kind <= maxD)
						prog.push_back(makeBranch(r[10:6], branch_e'(kind),
						                          r[20:11] % ((maxD - kind) / 8 + 1)));
					else
						prog.push_back(makeReg(ALU_R, r[10:6], r[15:11], 5'd0, ALU_XOR));
				end
				default: prog.push_back(makeJump(r[3] ? JAL : JUMP,
				                                 26'(prog.size() + 1 + r[20:8] % (maxD + 1))));
			endcase
		end
		prog.push_back(HaltWord);
	endtask

	initial begin
		rst = 1'b1;
		progWe = 1'b0;
		progAddr = '0;
		progData = '0;

		// ALU, register and immediate forms
		prog = '{makeImm(ALU_I, 1, 0, 16'h1230), makeImm(ALU_I, 2, 0, 16'h8000),
			makeReg(ALU_R, 1, 2, 0, ALU_ADD), makeReg(ALU_R, 2, 1, 0, ALU_SUB),
			makeReg(ALU_R, 1, 2, 0, ALU_AND), makeReg(ALU_R, 1, 2, 0, ALU_XOR),
			makeImm(ALU_I, 3, 0, 16'h0009), makeImm(ALU_I, 3, 0, 16'hfff2),
			makeImm(ALU_I, 3, 0, 16'h0f03), makeImm(ALU_I, 4, 0, 16'h8000),
			makeReg(SHIFT, 4, 0, 12, ALU_SRA), makeImm(ALU_I, 5, 0, 16'h8000),
			makeReg(SHIFT, 5, 0, 12, ALU_SRL), makeReg(SHIFT, 5, 0, 3, ALU_SLL),
			makeImm(ALU_I, 2, 0, 16'h0004), makeImm(ALU_I, 2, 0, 16'h0025),
			makeImm(ALU_I, 2, 0, 16'h0066), makeReg(ALU_R, 4, 3, 0, ALU_SRA), HaltWord};
		runTest("alu");

		// 0x108 and 0xff08 both wrap onto word 8
		prog = '{makeImm(ALU_I, 1, 0, 16'h0108), makeImm(ALU_I, 2, 0, 16'ha5a0),
			makeImm(ALU_I, 3, 0, 16'h1238), makeImm(STORE, 1, 2, 16'h0000),
			makeImm(STORE, 0, 3, 16'h0009), makeImm(STORE, 1, 3, 16'hffff),
			makeImm(LOAD, 0, 4, 16'h0008), makeImm(LOAD, 0, 5, 16'h0007),
			makeImm(LOAD, 1, 6, 16'h0001), makeImm(LOAD, 0, 7, 16'hff08), HaltWord};
		runTest("memory");

		prog.delete();
		prog.push_back(makeImm(ALU_I, 1, 0, 16'h8000));   // r1 negative
		prog.push_back(makeBranch(1, BR_BLTZ, 0));        // 1, taken
		addFiller(2);
		prog.push_back(makeBranch(0, BR_BLTZ, 0));
		prog.push_back(makeBranch(0, BR_BZ, 0));          // 5, taken
		addFiller(3);
		prog.push_back(makeBranch(1, BR_BZ, 0));
		prog.push_back(makeBranch(1, BR_BNZ, 0));         // 10, taken
		addFiller(4);
		prog.push_back(makeBranch(0, BR_BNZ, 0));
		prog.push_back(makeReg(ALU_R, 1, 1, 0, ALU_ADD)); // Carry out set
		prog.push_back(makeBranch(0, BR_BCY, 0));         // 17, taken
		addFiller(5);
		prog.push_back(makeBranch(0, BR_BNCY, 0));
		prog.push_back(makeImm(ALU_I, 2, 0, 16'h0001));   // 0 - 1 borrows
		prog.push_back(makeBranch(0, BR_BCY, 0));
		prog.push_back(makeBranch(0, BR_BNCY, 0));        // 26, taken
		addFiller(6);
		prog.push_back(makeReg(ALU_R, 1, 0, 0, ALU_SUB));
		prog.push_back(makeJump(JAL, 26'd40));            // Link is 35
		prog.push_back(makeJump(JUMP, 26'd38));
		addFiller(2);
		prog.push_back(HaltWord);                         // 38
		addFiller(1);
		prog.push_back(makeImm(JR, 31, 0, 16'h0000));     // 40, back to 35
		runTest("control");

		prog = '{makeImm(ALU_I, 1, 0, 16'h0050), makeImm(ALU_I, 0, 0, 16'h0128),
			makeReg(ALU_R, 1, 0, 0, ALU_ADD), makeReg(ALU_R, 0, 1, 0, ALU_XOR),
			makeImm(STORE, 0, 0, 16'h0020), HaltWord};
		runTest("r0 write");

		for (int t = 0; t < NumRandom; t++) begin
			buildRandom(RandLen);
			runTest($sformatf("random %0d", t));
		end

		$display("Tests: %0d, checks: %0d, errors: %0d", testCount, checkCount, errCount);
		if (errCount == 0)
			$display("TEST OK");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

// File: cpuTop.f
hdl/cpuPkg.sv
hdl/controlUnit.sv
hdl/instrDecoder.sv
hdl/regFile.sv
hdl/alu.sv
hdl/branchUnit.sv
hdl/instrMemory.sv
hdl/dataMemory.sv
hdl/dataPath.sv
hdl/cpuTop.sv
dv/cpuTb.sv
